//--- tb.f
isolde_pkg.sv
isolde_instr_window.sv
isolde_register_file.sv
isolde_decoder.sv
isolde_top.sv
isolde_top_chk.sv
tb_clk_gen.sv
tb_isolde_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_isolde_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_isolde_top.sv
// ----------------------------------------------------------------------
// Directed testbench for isolde_top with a register model
// Boot, vle32_4, vzero, vmv, stall, burst, illegal words, full window
// ----------------------------------------------------------------------

module tb_isolde_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MaxCycles   = 2000;  // About four times the full test run
  localparam int unsigned RespTimeout = 20;

  typedef logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] vreg_t;

  logic                                clk, rst_n, push;
  logic [isolde_pkg::RegDataWidth-1:0] word;
  logic [isolde_pkg::RegAddrWidth-1:0] dbg_raddr;
  vreg_t                               dbg_rdata;
  logic                                full, busy, done, illegal;

  vreg_t       model [isolde_pkg::RegCount];
  int unsigned value_errs = 0;
  int unsigned proto_errs = 0;
  int unsigned done_cnt = 0;
  int unsigned illegal_cnt = 0;
  int unsigned cycle_cnt;
  int          seed;

  tb_clk_gen i_clk_gen (.clk_o(clk));

  isolde_top i_isolde_top (
    .clk_i (clk), .rst_ni (rst_n), .push_i (push), .word_i (word),
    .dbg_raddr_i (dbg_raddr), .dbg_rdata_o (dbg_rdata), .full_o (full),
    .busy_o (busy), .done_o (done), .illegal_o (illegal)
  );

  bind isolde_top isolde_top_chk i_isolde_top_chk (
    .clk_i (clk_i), .rst_ni (rst_ni), .push_i (push_i), .full_i (full_o),
    .busy_i (busy_o), .done_i (done_o), .illegal_i (illegal_o),
    .pop_i (pop), .pop_cnt_i (pop_cnt), .count_i (count)
  );

  always @(negedge clk) begin  // Result pulse counters
    if (done === 1'b1) done_cnt++;
    if (illegal === 1'b1) illegal_cnt++;
  end

  function automatic logic [31:0] encode(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1);
    return {12'h000, rs1, f3, rd, isolde_pkg::IsoldeCustomOpcode};
  endfunction

  task automatic push_word(input logic [31:0] w);
    @(posedge clk);
    #1;
    push = 1'b1;
    word = w;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1 push = 1'b0;
    end
  endtask

  // Waits for the result pulse, then checks that exactly the expected one came
  task automatic wait_response(input bit exp_illegal);
    int unsigned d0, i0, waited;
    bit          seen;
    d0 = done_cnt;
    i0 = illegal_cnt;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < RespTimeout) begin
      @(posedge clk);
      #1 waited++;
      seen = (done_cnt != d0) || (illegal_cnt != i0);
    end
    assert (seen) else begin
      proto_errs++;
      $display("No done_o or illegal_o pulse within %0d cycles", RespTimeout);
    end
    idle_cycles(2);
    assert ((done_cnt - d0) == (exp_illegal ? 0 : 1) &&
            (illegal_cnt - i0) == (exp_illegal ? 1 : 0)) else begin
      value_errs++;
      $display("FAIL %0t: expected one %s pulse, saw %0d done and %0d illegal", $time,
               exp_illegal ? "illegal_o" : "done_o", done_cnt - d0, illegal_cnt - i0);
    end
  endtask

  task automatic run_single(input logic [31:0] w, input bit exp_illegal);
    push_word(w);
    idle_cycles(1);
    wait_response(exp_illegal);
  endtask

  task automatic check_reg(input int unsigned idx);
    @(posedge clk);
    #1 dbg_raddr = isolde_pkg::RegAddrWidth'(idx);
    @(negedge clk);
    assert (dbg_rdata === model[idx]) else begin
      value_errs++;
      $display("FAIL %0t: v%0d reads %h, expected %h", $time, idx, dbg_rdata, model[idx]);
    end
  endtask

  task automatic check_all_regs;
    for (int i = 0; i < isolde_pkg::RegCount; i++) check_reg(i);
  endtask

  // Five-word load of random data, word 1 lands in lane 3
  task automatic load_vreg(input int unsigned rd);
    logic [31:0] data [4];
    for (int k = 0; k < 4; k++) data[k] = $random(seed);
    push_word(encode(isolde_pkg::F3Vle32x4, 5'(rd), 5'd0));
    for (int k = 0; k < 4; k++) push_word(data[k]);
    idle_cycles(1);
    wait_response(1'b0);
    model[rd] = {data[0], data[1], data[2], data[3]};
  endtask

  task automatic test_boot;
    int unsigned busy_cycles;
    busy_cycles = 0;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (3 * isolde_pkg::RegCount) begin
      @(negedge clk);
      if (busy) busy_cycles++;
    end
    assert (busy_cycles == isolde_pkg::RegCount) else begin
      value_errs++;
      $display("FAIL %0t: busy_o high for %0d boot cycles", $time, busy_cycles);
    end
    for (int i = 0; i < isolde_pkg::RegCount; i++) model[i] = '0;
    check_all_regs();
  endtask

  task automatic test_vle32;
    for (int round = 0; round < 2; round++) begin
      for (int rd = 0; rd < isolde_pkg::RegCount; rd++) begin
        load_vreg(rd);
        check_reg(rd);
      end
    end
    check_all_regs();
  endtask

  task automatic test_vzero_vmv;
    run_single(encode(isolde_pkg::F3Vmv, 5'd1, 5'd4), 1'b0);
    model[1] = model[4];
    check_reg(1);
    run_single(encode(isolde_pkg::F3Vzero, 5'd4, 5'd0), 1'b0);
    model[4] = '0;
    run_single(encode(isolde_pkg::F3Vmv, 5'd0, 5'd4), 1'b0);
    model[0] = model[4];
    check_all_regs();
  endtask

  task automatic check_stalled(input int unsigned d0);
    @(negedge clk);
    assert (!busy) else begin
      value_errs++;
      $display("FAIL %0t: busy_o high while vle32_4 is incomplete", $time);
    end
    @(posedge clk);
    #1;
    assert (done_cnt == d0) else begin
      value_errs++;
      $display("FAIL %0t: done_o pulsed before the fifth word", $time);
    end
  endtask

  task automatic test_stall_burst;
    logic [31:0] data [4];
    int unsigned d0, i0, waited;
    for (int k = 0; k < 4; k++) data[k] = $random(seed);
    d0 = done_cnt;
    push_word(encode(isolde_pkg::F3Vle32x4, 5'd3, 5'd0));
    push_word(data[0]);
    idle_cycles(3);
    check_stalled(d0);
    push_word(data[1]);
    idle_cycles(2);
    check_stalled(d0);
    push_word(data[2]);
    idle_cycles(4);
    check_stalled(d0);
    push_word(data[3]);
    idle_cycles(1);
    wait_response(1'b0);
    model[3] = {data[0], data[1], data[2], data[3]};
    // Burst of one-word ops pushed back to back
    d0 = done_cnt;
    i0 = illegal_cnt;
    push_word(encode(isolde_pkg::F3Vmv, 5'd5, 5'd3));
    push_word(encode(isolde_pkg::F3Vzero, 5'd3, 5'd0));
    push_word(encode(isolde_pkg::F3Vmv, 5'd0, 5'd5));
    push_word(encode(isolde_pkg::F3Vzero, 5'd2, 5'd0));
    idle_cycles(1);
    waited = 0;
    while ((done_cnt - d0) < 4 && waited < 4 * RespTimeout) begin
      @(posedge clk);
      #1 waited++;
    end
    idle_cycles(2);
    assert ((done_cnt - d0) == 4 && illegal_cnt == i0) else begin
      value_errs++;
      $display("FAIL %0t: burst gave %0d done pulses, expected 4", $time, done_cnt - d0);
    end
    model[5] = model[3];
    model[3] = '0;
    model[0] = model[5];
    model[2] = '0;
    check_all_regs();
  endtask

  task automatic test_illegal;
    load_vreg(1);
    load_vreg(2);
    run_single({12'h000, 5'd0, isolde_pkg::F3Vzero, 5'd1, 7'h2B}, 1'b1);  // Wrong major
    check_all_regs();
    run_single(encode(3'b010, 5'd2, 5'd0), 1'b1);
    check_all_regs();
    run_single(encode(isolde_pkg::F3Vmv, 5'd3, 5'd1), 1'b0);
    model[3] = model[1];
    run_single(encode(isolde_pkg::F3Vzero, 5'd6, 5'd0), 1'b1);  // rd out of range
    run_single(encode(isolde_pkg::F3Vmv, 5'd2, 5'd7), 1'b1);    // rs1 out of range
    check_all_regs();
    run_single(encode(isolde_pkg::F3Vzero, 5'd1, 5'd0), 1'b0);
    model[1] = '0;
    check_all_regs();
  endtask

  // One-word ops pushed every cycle outrun the decoder until full_o rises
  task automatic test_full;
    int unsigned accepted, dropped, d0, i0, waited;
    accepted = 0;
    dropped = 0;
    waited = 0;
    d0 = done_cnt;
    i0 = illegal_cnt;
    while (dropped == 0 && accepted < 4 * isolde_pkg::WindowDepth) begin
      push_word(encode(isolde_pkg::F3Vzero, 5'd2, 5'd0));
      @(negedge clk);
      if (full) dropped++;  // This push is lost
      else accepted++;
    end
    idle_cycles(1);
    while ((done_cnt - d0) < accepted && waited < 4 * RespTimeout) begin
      @(posedge clk);
      #1 waited++;
    end
    idle_cycles(2);
    assert (dropped == 1) else begin
      proto_errs++;
      $display("full_o never rose while one-word ops were pushed every cycle");
    end
    assert ((done_cnt - d0) == accepted && illegal_cnt == i0) else begin
      value_errs++;
      $display("FAIL %0t: %0d pushes accepted but %0d done pulses", $time, accepted,
               done_cnt - d0);
    end
    model[2] = '0;
    check_all_regs();
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, tests did not finish", MaxCycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed = 32'h085d_645b;
    rst_n = 1'b0;
    push = 1'b0;
    word = '0;
    dbg_raddr = '0;
    test_boot();
    test_vle32();
    test_vzero_vmv();
    test_stall_burst();
    test_illegal();
    test_full();
    idle_cycles(2);
    $display("Errors: %0d value, %0d protocol, %0d assertion", value_errs, proto_errs,
             i_isolde_top.i_isolde_top_chk.fail_cnt);
    if (value_errs + proto_errs + i_isolde_top.i_isolde_top_chk.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
// ----------------------------------------------------------------------
// Testbench clock source, 4 ns period
// ----------------------------------------------------------------------

module tb_clk_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod = 2;

  initial clk_o = 1'b0;
  always #(HalfPeriod) clk_o = ~clk_o;

endmodule

//--- isolde_top_chk.sv
// ----------------------------------------------------------------------
// Protocol assertions bound into isolde_top
// Result pulses, window full behavior, quiet boot
// ----------------------------------------------------------------------

module isolde_top_chk (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            push_i,
  input logic                            full_i,
  input logic                            busy_i,
  input logic                            done_i,
  input logic                            illegal_i,
  input logic                            pop_i,
  input logic [isolde_pkg::CntWidth-1:0] pop_cnt_i,
  input logic [isolde_pkg::CntWidth-1:0] count_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [isolde_pkg::CntWidth-1:0] FullCount =
    isolde_pkg::CntWidth'(isolde_pkg::WindowDepth);

  int unsigned fail_cnt = 0;  // Read by the testbench
  logic        busy_seen_q;
  logic        boot_done_q;   // Set once the boot sweep has ended

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_seen_q <= 1'b0;
      boot_done_q <= 1'b0;
    end else begin
      if (busy_i) busy_seen_q <= 1'b1;
      if (busy_seen_q && !busy_i) boot_done_q <= 1'b1;
    end
  end

  done_illegal_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(done_i && illegal_i))
    else begin $error("done_o and illegal_o high together"); fail_cnt++; end

  // Push while full is dropped, only a pop may change the count
  full_drops_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (full_i && push_i) |=>
      (count_i == ($past(pop_i) ? FullCount - $past(pop_cnt_i) : FullCount)))
    else begin $error("push accepted while full_o was high"); fail_cnt++; end

  boot_no_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_i && !boot_done_q) |-> !done_i)
    else begin $error("done_o pulsed during boot"); fail_cnt++; end

endmodule

//--- isolde_top.sv
// ----------------------------------------------------------------------
// Top level of the ISOLDE slice
// Instruction window, decoder and vector register file
// ----------------------------------------------------------------------

module isolde_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                push_i,
  input  logic [isolde_pkg::RegDataWidth-1:0] word_i,
  input  logic [isolde_pkg::RegAddrWidth-1:0] dbg_raddr_i,
  output logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] dbg_rdata_o,
  output logic                                full_o,
  output logic                                busy_o,
  output logic                                done_o,
  output logic                                illegal_o
);

  logic [isolde_pkg::BatchWords-1:0][isolde_pkg::RegDataWidth-1:0] batch;
  logic [isolde_pkg::CntWidth-1:0]     count;
  logic                                pop;
  logic [isolde_pkg::CntWidth-1:0]     pop_cnt;
  logic [isolde_pkg::RegAddrWidth-1:0] rf_raddr;
  logic [isolde_pkg::RegAddrWidth-1:0] rf_waddr;
  logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] rf_rdata;
  logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] rf_wdata;
  logic                                rf_we;
  logic                                rf_err;

  isolde_instr_window i_instr_window (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (push_i),
    .word_i    (word_i),
    .pop_i     (pop),
    .pop_cnt_i (pop_cnt),
    .batch_o   (batch),
    .count_o   (count),
    .full_o    (full_o)
  );

  isolde_decoder i_decoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .batch_i    (batch),
    .count_i    (count),
    .rf_rdata_i (rf_rdata),
    .rf_err_i   (rf_err),
    .pop_o      (pop),
    .pop_cnt_o  (pop_cnt),
    .rf_raddr_o (rf_raddr),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .rf_we_o    (rf_we),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .illegal_o  (illegal_o)
  );

  isolde_register_file i_register_file (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .raddr_i     (rf_raddr),
    .waddr_i     (rf_waddr),
    .wdata_i     (rf_wdata),
    .we_i        (rf_we),
    .dbg_raddr_i (dbg_raddr_i),
    .rdata_o     (rf_rdata),
    .dbg_rdata_o (dbg_rdata_o),
    .err_o       (rf_err)
  );

endmodule

//--- isolde_decoder.sv
// ----------------------------------------------------------------------
// Decoder FSM for the variable-length custom instructions
// Boot clear of the register file, decode, execute and commit
// ----------------------------------------------------------------------

module isolde_decoder (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [isolde_pkg::BatchWords-1:0][isolde_pkg::RegDataWidth-1:0] batch_i,
  input  logic [isolde_pkg::CntWidth-1:0]     count_i,
  input  logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] rf_rdata_i,
  input  logic                                rf_err_i,
  output logic                                pop_o,
  output logic [isolde_pkg::CntWidth-1:0]     pop_cnt_o,
  output logic [isolde_pkg::RegAddrWidth-1:0] rf_raddr_o,
  output logic [isolde_pkg::RegAddrWidth-1:0] rf_waddr_o,
  output logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] rf_wdata_o,
  output logic                                rf_we_o,
  output logic                                busy_o,
  output logic                                done_o,
  output logic                                illegal_o
);

  isolde_pkg::decoder_state_e state_q;
  isolde_pkg::decoder_state_e state_d;
  isolde_pkg::isolde_opcode_e dec_op;
  isolde_pkg::isolde_opcode_e op_q;

  logic [isolde_pkg::CntWidth-1:0]     dec_len;
  logic [isolde_pkg::CntWidth-1:0]     len_q;
  logic [isolde_pkg::RegAddrWidth-1:0] rd_q;
  logic [isolde_pkg::RegAddrWidth-1:0] rs1_q;
  logic [isolde_pkg::RegAddrWidth-1:0] boot_ptr_q;
  logic                                boot_run_q;  // Boot sweep starts after release
  logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] data_q;
  logic                                accept;
  logic                                boot_we;
  logic                                exec_ok;

  // Opcode and length of the first word, illegal words count as one word
  function automatic void decode_word(
    input  logic [isolde_pkg::RegDataWidth-1:0] word,
    output isolde_pkg::isolde_opcode_e          op,
    output logic [isolde_pkg::CntWidth-1:0]     len
  );
    op  = isolde_pkg::isolde_opcode_none;
    len = isolde_pkg::LenSingle;
    if (word[isolde_pkg::OpcodeMsb:0] == isolde_pkg::IsoldeCustomOpcode) begin
      case (word[isolde_pkg::Funct3Msb:isolde_pkg::Funct3Lsb])
        isolde_pkg::F3Vle32x4: begin
          op  = isolde_pkg::isolde_opcode_vle32_4;
          len = isolde_pkg::LenVle32x4;
        end
        isolde_pkg::F3Vzero: op = isolde_pkg::isolde_opcode_vzero;
        isolde_pkg::F3Vmv:   op = isolde_pkg::isolde_opcode_vmv;
        default:             op = isolde_pkg::isolde_opcode_none;
      endcase
    end
  endfunction

  always_comb begin
    decode_word(batch_i[0], dec_op, dec_len);
  end

  // COMMIT accepts like IDLE, so back-to-back takes two cycles
  assign accept = ((state_q == isolde_pkg::IDLE) || (state_q == isolde_pkg::COMMIT)) &&
                  (count_i >= dec_len);

  always_comb begin
    state_d = state_q;
    case (state_q)
      isolde_pkg::BOOT: begin
        if (boot_run_q && (boot_ptr_q == isolde_pkg::RegLastAddr)) begin
          state_d = isolde_pkg::IDLE;
        end
      end
      isolde_pkg::IDLE:    state_d = accept ? isolde_pkg::EXECUTE : isolde_pkg::IDLE;
      isolde_pkg::EXECUTE: state_d = isolde_pkg::COMMIT;
      isolde_pkg::COMMIT:  state_d = accept ? isolde_pkg::EXECUTE : isolde_pkg::IDLE;
      default:             state_d = isolde_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= isolde_pkg::BOOT;
      boot_run_q <= 1'b0;
      boot_ptr_q <= '0;
      op_q       <= isolde_pkg::isolde_opcode_none;
      len_q      <= isolde_pkg::LenSingle;
      rd_q       <= '0;
      rs1_q      <= '0;
    end else begin
      state_q    <= state_d;
      boot_run_q <= 1'b1;
      if (boot_we) begin
        boot_ptr_q <= boot_ptr_q + 1'b1;
      end
      if (accept) begin
        op_q  <= dec_op;
        len_q <= dec_len;
        rd_q  <= batch_i[0][isolde_pkg::RdLsb +: isolde_pkg::RegAddrWidth];
        rs1_q <= batch_i[0][isolde_pkg::Rs1Lsb +: isolde_pkg::RegAddrWidth];
      end
    end
  end

  // Trailing data words, word 1 goes to the top lane
  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int i = 0; i < isolde_pkg::RegLanes; i++) begin
        data_q[isolde_pkg::RegLanes-1-i] <= batch_i[i+1];
      end
    end
  end

  assign boot_we = (state_q == isolde_pkg::BOOT) && boot_run_q;

  // Only vmv reads, other ops park the read port on register 0
  assign rf_raddr_o = (op_q == isolde_pkg::isolde_opcode_vmv) ? rs1_q : '0;
  assign rf_waddr_o = (state_q == isolde_pkg::BOOT) ? boot_ptr_q : rd_q;

  always_comb begin
    rf_wdata_o = '0;  // Boot and vzero write zeros
    if (state_q != isolde_pkg::BOOT) begin
      case (op_q)
        isolde_pkg::isolde_opcode_vle32_4: rf_wdata_o = data_q;
        isolde_pkg::isolde_opcode_vmv:     rf_wdata_o = rf_rdata_i;
        default:                           rf_wdata_o = '0;
      endcase
    end
  end

  // Range errors from the register file turn the op into an illegal one
  assign exec_ok = (state_q == isolde_pkg::EXECUTE) &&
                   (op_q != isolde_pkg::isolde_opcode_none) && !rf_err_i;

  assign rf_we_o   = boot_we || exec_ok;
  assign done_o    = exec_ok;
  assign illegal_o = (state_q == isolde_pkg::EXECUTE) && !exec_ok;
  assign pop_o     = (state_q == isolde_pkg::EXECUTE);
  assign pop_cnt_o = len_q;
  assign busy_o    = boot_we || (state_q == isolde_pkg::EXECUTE);

endmodule

//--- isolde_register_file.sv
// ----------------------------------------------------------------------
// Vector register file, six entries of four 32-bit lanes
// Decoder read port, debug read port, one write port, range error
// ----------------------------------------------------------------------

module isolde_register_file (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [isolde_pkg::RegAddrWidth-1:0] raddr_i,
  input  logic [isolde_pkg::RegAddrWidth-1:0] waddr_i,
  input  logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] wdata_i,
  input  logic                                we_i,
  input  logic [isolde_pkg::RegAddrWidth-1:0] dbg_raddr_i,
  output logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] rdata_o,
  output logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] dbg_rdata_o,
  output logic                                err_o
);

  logic [isolde_pkg::RegLanes-1:0][isolde_pkg::RegDataWidth-1:0] regs_q [isolde_pkg::RegCount];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < isolde_pkg::RegCount; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      // Addresses 6 and 7 match no entry and are dropped
      for (int i = 0; i < isolde_pkg::RegCount; i++) begin
        if (waddr_i == i[isolde_pkg::RegAddrWidth-1:0]) begin
          regs_q[i] <= wdata_i;
        end
      end
    end
  end

  // Combinational reads, zero when out of range
  assign rdata_o     = (raddr_i < isolde_pkg::RegCount) ? regs_q[raddr_i] : '0;
  assign dbg_rdata_o = (dbg_raddr_i < isolde_pkg::RegCount) ? regs_q[dbg_raddr_i] : '0;

  // Either decoder-side address out of range
  assign err_o = (raddr_i >= isolde_pkg::RegCount) || (waddr_i >= isolde_pkg::RegCount);

endmodule

//--- isolde_instr_window.sv
// ----------------------------------------------------------------------
// Instruction window, eight-word circular FIFO
// Presents the five oldest words and pops a variable word count
// ----------------------------------------------------------------------

module isolde_instr_window (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                push_i,     // One word per strobe
  input  logic [isolde_pkg::RegDataWidth-1:0] word_i,
  input  logic                                pop_i,
  input  logic [isolde_pkg::CntWidth-1:0]     pop_cnt_i,
  output logic [isolde_pkg::BatchWords-1:0][isolde_pkg::RegDataWidth-1:0] batch_o,
  output logic [isolde_pkg::CntWidth-1:0]     count_o,
  output logic                                full_o
);

  logic [isolde_pkg::RegDataWidth-1:0] mem_q [isolde_pkg::WindowDepth];

  logic [isolde_pkg::WinPtrWidth-1:0] wr_ptr_q;
  logic [isolde_pkg::WinPtrWidth-1:0] rd_ptr_q;
  logic [isolde_pkg::CntWidth-1:0]    count_q;
  logic [isolde_pkg::CntWidth-1:0]    count_d;
  logic                               push_acc;

  assign full_o   = (count_q == isolde_pkg::WindowDepth);
  assign push_acc = push_i & ~full_o;  // Push while full is lost
  assign count_o  = count_q;

  // Push and pop may land in the same cycle
  always_comb begin
    count_d = count_q;
    if (push_acc) begin
      count_d = count_d + 1'b1;
    end
    if (pop_i) begin
      count_d = count_d - pop_cnt_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_acc) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at the depth
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + pop_cnt_i[isolde_pkg::WinPtrWidth-1:0];
      end
      count_q <= count_d;
    end
  end

  // Word storage
  always_ff @(posedge clk_i) begin
    if (push_acc) begin
      mem_q[wr_ptr_q] <= word_i;
    end
  end

  // Oldest words first, empty slots read as zero
  always_comb begin
    for (int i = 0; i < isolde_pkg::BatchWords; i++) begin
      if (count_q > i[isolde_pkg::CntWidth-1:0]) begin
        batch_o[i] = mem_q[rd_ptr_q + i[isolde_pkg::WinPtrWidth-1:0]];
      end else begin
        batch_o[i] = '0;
      end
    end
  end

endmodule

//--- isolde_pkg.sv
// ----------------------------------------------------------------------
// Shared sizes, field positions and encodings for the ISOLDE slice
// Opcode and decoder state enums
// ----------------------------------------------------------------------

package isolde_pkg;

  // Vector register file geometry
  localparam int unsigned RegDataWidth = 32;  // One lane is one word
  localparam int unsigned RegLanes     = 4;
  localparam int unsigned RegCount     = 6;
  localparam int unsigned RegAddrWidth = 3;   // 6 and 7 are out of range

  // Highest implemented register, end of the boot sweep
  localparam logic [RegAddrWidth-1:0] RegLastAddr = RegAddrWidth'(RegCount - 1);

  // Instruction window
  localparam int unsigned BatchWords  = 5;    // Longest instruction
  localparam int unsigned WindowDepth = 8;
  localparam int unsigned WinPtrWidth = 3;
  localparam int unsigned CntWidth    = 4;    // Holds 0 to WindowDepth

  // Instruction lengths in words
  localparam logic [CntWidth-1:0] LenVle32x4 = 4'd5;
  localparam logic [CntWidth-1:0] LenSingle  = 4'd1;

  // Field positions in the first word
  localparam int unsigned OpcodeMsb = 6;
  localparam int unsigned RdLsb     = 7;
  localparam int unsigned Funct3Lsb = 12;
  localparam int unsigned Funct3Msb = 14;
  localparam int unsigned Rs1Lsb    = 15;

  // Custom-0 major opcode
  localparam logic [6:0] IsoldeCustomOpcode = 7'h0B;

  // funct3 codes
  localparam logic [2:0] F3Vle32x4 = 3'b100;
  localparam logic [2:0] F3Vzero   = 3'b000;
  localparam logic [2:0] F3Vmv     = 3'b001;

  typedef enum logic [1:0] {
    isolde_opcode_none,     // Illegal encoding
    isolde_opcode_vle32_4,
    isolde_opcode_vzero,
    isolde_opcode_vmv
  } isolde_opcode_e;

  typedef enum logic [1:0] {
    BOOT,
    IDLE,
    EXECUTE,
    COMMIT
  } decoder_state_e;

endpackage
